//--- source/apu_pkg.sv
package apu_pkg;

	typedef logic [31:0] apu_word_t;
	typedef logic [1:0]  apu_size_t;      // 0..3 -> 8, 16, 24, 32 bits
	typedef logic [2:0]  apu_reg_addr_t;

	localparam int APU_NUM_REGS = 8;
	localparam int APU_PADDR_W  = 8;

	// Byte offsets on the APB
	localparam logic [APU_PADDR_W-1:0] APU_ADDR_CMD      = 8'h00;
	localparam logic [APU_PADDR_W-1:0] APU_ADDR_STATUS   = 8'h04;   // busy, zero, sign, carry
	localparam logic [APU_PADDR_W-1:0] APU_ADDR_REG_BASE = 8'h20;   // Reg n at base + 4n

	typedef enum logic [3:0] {
		LOAD, AND, OR, XOR,
		ADD, SUB, ADC, SBC,
		RL, RR, RLC, RRC,
		SRA, SRZ, NOP, MUL
	} apu_func_e;

	// Register fields are nibble aligned, use_imm sits at bit 20
	typedef struct packed {
		logic [7:0]    imm;
		logic [2:0]    spare_hi;
		logic          use_imm;
		logic          pad_arg;
		apu_reg_addr_t arg_reg;
		logic          pad_src;
		apu_reg_addr_t src_reg;
		logic          pad_dst;
		apu_reg_addr_t dst_reg;
		logic [1:0]    spare_lo;
		apu_size_t     size;
		apu_func_e     func;
	} apu_cmd_t;

	typedef struct packed {
		logic zero;
		logic sign;
		logic carry;
	} apu_flags_t;

	typedef struct packed {
		apu_word_t src;
		apu_word_t arg;
		logic      carry_in;
		apu_func_e func;
		apu_size_t size;
	} apu_alu_in_t;

	typedef struct packed {
		apu_word_t  result;
		apu_flags_t flags;
	} apu_alu_out_t;

	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		WRITEBACK
	} apu_state_e;

endpackage

//--- source/apu_alu.sv
`timescale 1ns/1ps

module apu_alu (
	input  apu_pkg::apu_alu_in_t  alu_in,
	output apu_pkg::apu_alu_out_t alu_out
);

	apu_pkg::apu_word_t mask;
	apu_pkg::apu_word_t src_m;
	apu_pkg::apu_word_t arg_m;
	apu_pkg::apu_word_t res;
	logic [4:0]         msb;
	logic [5:0]         cbit;
	logic [32:0]        sum;
	logic [32:0]        diff;
	logic [63:0]        prod;
	logic               cin;
	logic               top;
	logic               lc;
	logic               rc;
	logic               carry;
	logic               zero;
	logic               sign;

	assign msb   = {alu_in.size, 3'b111};                      // 7, 15, 23 or 31
	assign cbit  = {1'b0, msb} + 6'd1;                         // First bit above size
	assign mask  = 32'hffff_ffff >> {~alu_in.size, 3'b000};
	assign src_m = alu_in.src & mask;
	assign arg_m = alu_in.arg & mask;
	assign top   = alu_in.src[msb];

	// Carry only enters ADC and SBC
	assign cin = alu_in.carry_in &&
		(alu_in.func == apu_pkg::ADC || alu_in.func == apu_pkg::SBC);

	assign sum  = {1'b0, src_m} + {1'b0, arg_m} + {32'd0, cin};
	assign diff = {1'b0, src_m} - {1'b0, arg_m} - {32'd0, cin};   // Borrow above size
	assign prod = {32'd0, src_m} * {32'd0, arg_m};

	assign lc = (alu_in.func == apu_pkg::RLC) ? alu_in.carry_in : top;

	// Bit shifted in at the top on right moves
	always_comb begin
		case (alu_in.func)
			apu_pkg::RR:  rc = alu_in.src[0];
			apu_pkg::RRC: rc = alu_in.carry_in;
			apu_pkg::SRA: rc = top;
			default:      rc = 1'b0;                          // SRZ
		endcase
	end

	always_comb begin
		res   = alu_in.src;
		carry = 1'b0;
		case (alu_in.func)
			apu_pkg::LOAD: res = alu_in.arg;
			apu_pkg::AND: res = alu_in.src & alu_in.arg;
			apu_pkg::OR:  res = alu_in.src | alu_in.arg;
			apu_pkg::XOR: res = alu_in.src ^ alu_in.arg;
			apu_pkg::ADD,
			apu_pkg::ADC: begin
				res   = sum[31:0] & mask;
				carry = sum[cbit];
			end
			apu_pkg::SUB,
			apu_pkg::SBC: begin
				res   = diff[31:0] & mask;
				carry = diff[cbit];
			end
			apu_pkg::RL,
			apu_pkg::RLC: begin
				res   = {alu_in.src[30:0], lc} & mask;
				carry = top;
			end
			apu_pkg::RR,
			apu_pkg::RRC,
			apu_pkg::SRA,
			apu_pkg::SRZ: begin
				res   = (src_m >> 1) | ({31'd0, rc} << msb);
				carry = alu_in.src[0];
			end
			apu_pkg::MUL: begin
				res   = prod[31:0] & mask;
				carry = prod[cbit];
			end
			default: res = alu_in.src;                      // NOP
		endcase
	end

	// Flags at the selected size
	assign zero = (res & mask) == '0;
	assign sign = res[msb];

	assign alu_out = '{
		result: res,
		flags:  '{zero: zero, sign: sign, carry: carry}
	};

endmodule

//--- source/apu_regfile.sv
`timescale 1ns/1ps

module apu_regfile (
	input  logic                   clk,
	input  logic                   reset,
	input  apu_pkg::apu_reg_addr_t src_idx,
	input  apu_pkg::apu_reg_addr_t arg_idx,
	input  apu_pkg::apu_reg_addr_t host_idx,
	input  logic                   wr_en,
	input  apu_pkg::apu_reg_addr_t wr_idx,
	input  apu_pkg::apu_word_t     wr_data,
	output apu_pkg::apu_word_t     src_data,
	output apu_pkg::apu_word_t     arg_data,
	output apu_pkg::apu_word_t     host_data
);

	apu_pkg::apu_word_t regs [apu_pkg::APU_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < apu_pkg::APU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Asynchronous reads
	assign src_data  = regs[src_idx];
	assign arg_data  = regs[arg_idx];
	assign host_data = regs[host_idx];

endmodule

//--- source/apu_ctrl.sv
`timescale 1ns/1ps

module apu_ctrl (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [apu_pkg::APU_PADDR_W-1:0] paddr,
	input  apu_pkg::apu_word_t              pwdata,
	input  apu_pkg::apu_word_t              src_data,
	input  apu_pkg::apu_word_t              arg_data,
	input  apu_pkg::apu_word_t              host_data,
	input  apu_pkg::apu_alu_out_t           alu_out,
	output apu_pkg::apu_word_t              prdata,
	output logic                            pready,
	output logic                            pslverr,
	output apu_pkg::apu_reg_addr_t          src_idx,
	output apu_pkg::apu_reg_addr_t          arg_idx,
	output apu_pkg::apu_reg_addr_t          host_idx,
	output logic                            wr_en,
	output apu_pkg::apu_reg_addr_t          wr_idx,
	output apu_pkg::apu_word_t              wr_data,
	output apu_pkg::apu_alu_in_t            alu_in
);

	// Keeps bits 7:5 and 1:0 for the register window
	localparam logic [apu_pkg::APU_PADDR_W-1:0] REG_ADDR_MASK = 8'he3;

	apu_pkg::apu_state_e   state;
	apu_pkg::apu_cmd_t     cmd_q;
	apu_pkg::apu_alu_out_t result_q;
	apu_pkg::apu_flags_t   flags_q;
	apu_pkg::apu_word_t    status_word;
	apu_pkg::apu_word_t    arg_word;
	logic                  is_cmd;
	logic                  is_status;
	logic                  is_reg;
	logic                  map_err;
	logic                  busy;
	logic                  stall;
	logic                  xfer;
	logic                  cmd_wr;
	logic                  reg_wr;
	logic                  writeback;

	assign is_cmd    = paddr == apu_pkg::APU_ADDR_CMD;
	assign is_status = paddr == apu_pkg::APU_ADDR_STATUS;
	assign is_reg    = (paddr & REG_ADDR_MASK) == apu_pkg::APU_ADDR_REG_BASE;
	assign map_err   = !(is_cmd || is_status || is_reg);

	assign busy      = state != apu_pkg::IDLE;
	assign writeback = state == apu_pkg::WRITEBACK;
	assign stall     = busy && (is_cmd || is_reg);           // Hold off until IDLE

	assign pready  = psel && penable && !stall;
	assign pslverr = pready && (map_err || (pwrite && is_status));
	assign xfer    = pready && !pslverr;
	assign cmd_wr  = xfer && pwrite && is_cmd;
	assign reg_wr  = xfer && pwrite && is_reg;

	assign status_word = {28'd0, flags_q.carry, flags_q.sign, flags_q.zero, busy};

	always_comb begin
		prdata = '0;
		if (xfer && !pwrite) begin
			if (is_status)
				prdata = status_word;
			else if (is_reg)
				prdata = host_data;
			else
				prdata = cmd_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= apu_pkg::IDLE;
			cmd_q   <= '0;
			flags_q <= '0;
		end else begin
			case (state)
				apu_pkg::IDLE: begin
					if (cmd_wr) begin
						cmd_q <= apu_pkg::apu_cmd_t'(pwdata);
						state <= apu_pkg::EXEC;
					end
				end
				apu_pkg::EXEC: state <= apu_pkg::WRITEBACK;
				apu_pkg::WRITEBACK: begin
					flags_q <= result_q.flags;
					state   <= apu_pkg::IDLE;
				end
				default: state <= apu_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == apu_pkg::EXEC)
			result_q <= alu_out;
	end

	assign host_idx = paddr[4:2];
	assign src_idx  = cmd_q.src_reg;
	assign arg_idx  = cmd_q.arg_reg;

	// Host writes never overlap writeback, they stall while busy
	assign wr_en   = writeback || reg_wr;
	assign wr_idx  = writeback ? cmd_q.dst_reg : host_idx;
	assign wr_data = writeback ? result_q.result : pwdata;

	assign arg_word = cmd_q.use_imm ? {24'd0, cmd_q.imm} : arg_data;

	assign alu_in = '{
		src:      src_data,
		arg:      arg_word,
		carry_in: flags_q.carry,
		func:     cmd_q.func,
		size:     cmd_q.size
	};

endmodule

//--- source/apu_top.sv
`timescale 1ns/1ps

module apu_top (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [apu_pkg::APU_PADDR_W-1:0] paddr,
	input  apu_pkg::apu_word_t              pwdata,
	output apu_pkg::apu_word_t              prdata,
	output logic                            pready,
	output logic                            pslverr
);

	apu_pkg::apu_reg_addr_t src_idx;
	apu_pkg::apu_reg_addr_t arg_idx;
	apu_pkg::apu_reg_addr_t host_idx;
	apu_pkg::apu_reg_addr_t wr_idx;
	apu_pkg::apu_word_t     wr_data;
	apu_pkg::apu_word_t     src_data;
	apu_pkg::apu_word_t     arg_data;
	apu_pkg::apu_word_t     host_data;
	apu_pkg::apu_alu_in_t   alu_in;
	apu_pkg::apu_alu_out_t  alu_out;
	logic                   wr_en;

	apu_ctrl apu_ctrl_i (
		.clk       (clk),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.src_data  (src_data),
		.arg_data  (arg_data),
		.host_data (host_data),
		.alu_out   (alu_out),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.src_idx   (src_idx),
		.arg_idx   (arg_idx),
		.host_idx  (host_idx),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data),
		.alu_in    (alu_in)
	);

	apu_alu apu_alu_i (
		.alu_in  (alu_in),
		.alu_out (alu_out)
	);

	apu_regfile apu_regfile_i (
		.clk       (clk),
		.reset     (reset),
		.src_idx   (src_idx),
		.arg_idx   (arg_idx),
		.host_idx  (host_idx),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data),
		.src_data  (src_data),
		.arg_data  (arg_data),
		.host_data (host_data)
	);

endmodule

//--- sim/apu_model.svh
`ifndef APU_MODEL_SVH
`define APU_MODEL_SVH

// Expected ALU response for one command, n = 8 * (size + 1) bits wide
function automatic apu_pkg::apu_alu_out_t expect_alu(
	input apu_pkg::apu_word_t src,
	input apu_pkg::apu_word_t arg,
	input logic               cin,
	input apu_pkg::apu_func_e func,
	input apu_pkg::apu_size_t size
);
	int                    n;
	logic [63:0]           mask;
	logic [63:0]           a;
	logic [63:0]           b;
	logic [63:0]           c;
	logic [63:0]           r;
	logic                  top;
	logic                  in_bit;
	logic                  carry;
	logic                  sized;
	apu_pkg::apu_alu_out_t res;

	n     = 8 * (int'(size) + 1);
	mask  = (64'd1 << n) - 64'd1;
	a     = {32'd0, src} & mask;
	b     = {32'd0, arg} & mask;
	top   = src[n-1];
	carry = 1'b0;
	sized = !(func inside {apu_pkg::LOAD, apu_pkg::AND, apu_pkg::OR, apu_pkg::XOR,
		apu_pkg::NOP});
	c     = (func == apu_pkg::ADC || func == apu_pkg::SBC) ? {63'd0, cin} : 64'd0;
	in_bit = (func == apu_pkg::RR)  ? src[0] :
		(func == apu_pkg::RRC) ? cin :
		(func == apu_pkg::SRA) ? top : 1'b0;

	case (func)
		apu_pkg::LOAD: r = {32'd0, arg};
		apu_pkg::AND: r = {32'd0, src & arg};
		apu_pkg::OR:  r = {32'd0, src | arg};
		apu_pkg::XOR: r = {32'd0, src ^ arg};
		apu_pkg::ADD,
		apu_pkg::ADC: begin
			r     = a + b + c;
			carry = r[n];
		end
		apu_pkg::SUB,
		apu_pkg::SBC: begin
			r     = a - b - c;
			carry = a < (b + c);                           // Borrow
		end
		apu_pkg::RL,
		apu_pkg::RLC: begin
			r     = (a << 1) | {63'd0, (func == apu_pkg::RLC) ? cin : top};
			carry = top;
		end
		apu_pkg::RR,
		apu_pkg::RRC,
		apu_pkg::SRA,
		apu_pkg::SRZ: begin
			r     = (a >> 1) | ({63'd0, in_bit} << (n - 1));
			carry = src[0];
		end
		apu_pkg::MUL: begin
			r     = a * b;
			carry = r[n];
		end
		default: r = {32'd0, src};                        // NOP
	endcase

	if (sized)
		r = r & mask;
	res.result      = r[31:0];
	res.flags.zero  = (r & mask) == 64'd0;
	res.flags.sign  = r[n-1];
	res.flags.carry = carry;
	return res;
endfunction

`endif

//--- sim/apu_tb.sv
`timescale 1ns/1ps

module apu_tb;

	localparam int CLK_HALF    = 10;
	localparam int XFER_CYCLES = 3;                        // Setup, access, one stall
	localparam int TEST_XFERS  = 17 + 53 + 112 + 384 + 29 + 13;
	localparam int CYCLE_LIMIT = 2 * TEST_XFERS * XFER_CYCLES + 4;

	logic                            clk;
	logic                            reset;
	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [apu_pkg::APU_PADDR_W-1:0] paddr;
	apu_pkg::apu_word_t              pwdata;
	apu_pkg::apu_word_t              prdata;
	logic                            pready;
	logic                            pslverr;

	apu_pkg::apu_word_t  model_regs [apu_pkg::APU_NUM_REGS];
	apu_pkg::apu_flags_t model_flags;
	integer              seed;
	int                  cycles = 0;
	int                  last_waits;
	int                  word_errs;
	int                  flag_errs;
	int                  resp_errs;
	int                  proto_errs;

	`include "apu_model.svh"

	apu_top apu_top_i (
		.clk     (clk),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Called at 1 ns after an edge, returns at the same point
	task automatic apb_transfer(
		input  logic                            write,
		input  logic [apu_pkg::APU_PADDR_W-1:0] addr,
		input  apu_pkg::apu_word_t              wdata,
		output apu_pkg::apu_word_t              rdata,
		output logic                            err
	);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1 penable = 1'b1;
		last_waits = 0;
		@(negedge clk);
		while (!pready) begin
			last_waits++;
			@(negedge clk);
		end
		rdata = prdata;                                    // Sampled mid cycle
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input apu_pkg::apu_word_t data,
		output logic err);
		apu_pkg::apu_word_t unused_rdata;
		apb_transfer(1'b1, addr, data, unused_rdata, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output apu_pkg::apu_word_t data,
		output logic err);
		apb_transfer(1'b0, addr, 32'd0, data, err);
	endtask

	function automatic logic [7:0] reg_addr(input apu_pkg::apu_reg_addr_t idx);
		return apu_pkg::APU_ADDR_REG_BASE + {3'd0, idx, 2'b00};
	endfunction

	task automatic check_word(input string name, input apu_pkg::apu_word_t exp,
		input apu_pkg::apu_word_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s: expected %h, actual %h", $time, name, exp, act);
			word_errs++;
		end
	endtask

	task automatic check_flags(input string name, input apu_pkg::apu_flags_t exp,
		input apu_pkg::apu_flags_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s (zero sign carry): expected %b, actual %b",
				$time, name, exp, act);
			flag_errs++;
		end
	endtask

	task automatic check_resp(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s: expected %b, actual %b", $time, name, exp, act);
			resp_errs++;
		end
	endtask

	task automatic check_busy(input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t status busy: expected %b, actual %b", $time, exp, act);
			proto_errs++;
		end
	endtask

	task automatic check_no_wait(input string what);
		if (last_waits != 0) begin
			$display("%0t: %s took %0d wait states while idle", $time, what, last_waits);
			proto_errs++;
		end
	endtask

	task automatic load_reg(input apu_pkg::apu_reg_addr_t idx, input apu_pkg::apu_word_t value);
		logic err;
		apb_write(reg_addr(idx), value, err);
		check_resp("pslverr on register write", 1'b0, err);
		model_regs[idx] = value;
	endtask

	task automatic read_reg_check(input apu_pkg::apu_reg_addr_t idx);
		apu_pkg::apu_word_t data;
		logic               err;
		apb_read(reg_addr(idx), data, err);
		check_resp("pslverr on register read", 1'b0, err);
		check_word($sformatf("r%0d", idx), model_regs[idx], data);
	endtask

	task automatic read_status_check(input logic busy_exp);
		apu_pkg::apu_word_t  data;
		apu_pkg::apu_flags_t act;
		logic                err;
		apb_read(apu_pkg::APU_ADDR_STATUS, data, err);
		act.zero  = data[1];
		act.sign  = data[2];
		act.carry = data[3];
		check_resp("pslverr on status read", 1'b0, err);
		check_busy(busy_exp, data[0]);
		check_flags("status flags", model_flags, act);
	endtask

	// Writes the command and advances the model, no readback
	task automatic issue_cmd(input apu_pkg::apu_func_e func, input apu_pkg::apu_size_t size,
		input apu_pkg::apu_reg_addr_t dst, input apu_pkg::apu_reg_addr_t src,
		input apu_pkg::apu_reg_addr_t argr, input logic use_imm, input logic [7:0] imm);
		apu_pkg::apu_cmd_t     cmd;
		apu_pkg::apu_word_t    arg;
		apu_pkg::apu_alu_out_t exp;
		logic                  err;
		cmd         = '0;
		cmd.func    = func;
		cmd.size    = size;
		cmd.dst_reg = dst;
		cmd.src_reg = src;
		cmd.arg_reg = argr;
		cmd.use_imm = use_imm;
		cmd.imm     = imm;
		arg = use_imm ? {24'd0, imm} : model_regs[argr];
		exp = expect_alu(model_regs[src], arg, model_flags.carry, func, size);
		apb_write(apu_pkg::APU_ADDR_CMD, cmd, err);
		check_resp($sformatf("pslverr on %s command", func.name()), 1'b0, err);
		model_regs[dst] = exp.result;
		model_flags     = exp.flags;
	endtask

	task automatic run_cmd(input apu_pkg::apu_func_e func, input apu_pkg::apu_size_t size,
		input apu_pkg::apu_reg_addr_t dst, input apu_pkg::apu_reg_addr_t src,
		input apu_pkg::apu_reg_addr_t argr, input logic use_imm, input logic [7:0] imm);
		issue_cmd(func, size, dst, src, argr, use_imm, imm);
		read_reg_check(dst);
		read_status_check(1'b0);
	endtask

	task automatic set_carry(input logic c);
		load_reg(3'd7, {31'd0, c});
		run_cmd(apu_pkg::SRZ, 2'd0, 3'd6, 3'd7, 3'd0, 1'b0, 8'd0);   // Bit 0 into carry
	endtask

	task automatic test_reg_access();
		apu_pkg::apu_word_t data;
		logic               err;
		apb_read(apu_pkg::APU_ADDR_STATUS, data, err);
		check_word("status after reset", 32'd0, data);
		check_no_wait("status read");
		for (int i = 0; i < 8; i++) begin
			load_reg(3'(i), $random(seed));
			check_no_wait("register write");
		end
		for (int i = 0; i < 8; i++) begin
			read_reg_check(3'(i));
			check_no_wait("register read");
		end
	endtask

	task automatic test_logic();
		apu_pkg::apu_func_e ops [5] = '{apu_pkg::LOAD, apu_pkg::AND, apu_pkg::OR,
			apu_pkg::XOR, apu_pkg::NOP};
		for (int i = 0; i < 5; i++) begin
			for (int k = 0; k < 2; k++) begin
				load_reg(3'd1, $random(seed));
				load_reg(3'd2, $random(seed));
				run_cmd(ops[i], 2'(i + k), 3'd3, 3'd1, 3'd2, k == 1, 8'($random(seed)));
			end
		end
		run_cmd(apu_pkg::XOR, 2'd3, 3'd4, 3'd1, 3'd1, 1'b0, 8'd0);  // Zero result
	endtask

	task automatic test_arith();
		apu_pkg::apu_func_e ops [4] = '{apu_pkg::ADD, apu_pkg::SUB, apu_pkg::ADC, apu_pkg::SBC};
		for (int s = 0; s < 4; s++) begin
			for (int i = 0; i < 4; i++) begin
				load_reg(3'd1, $random(seed));
				load_reg(3'd2, $random(seed));
				run_cmd(ops[i], 2'(s), 3'd3, 3'd1, 3'd2, 1'b0, 8'd0);
			end
		end
		for (int s = 0; s < 4; s++) begin
			load_reg(3'd1, 32'hffff_ffff);
			load_reg(3'd2, 32'd1);
			run_cmd(apu_pkg::ADD, 2'(s), 3'd3, 3'd1, 3'd2, 1'b0, 8'd0);   // Overflows
			run_cmd(apu_pkg::ADC, 2'(s), 3'd4, 3'd1, 3'd2, 1'b0, 8'd0);
		end
	endtask

	task automatic test_shift();
		apu_pkg::apu_func_e ops [6] = '{apu_pkg::RL, apu_pkg::RR, apu_pkg::RLC,
			apu_pkg::RRC, apu_pkg::SRA, apu_pkg::SRZ};
		for (int c = 0; c < 2; c++) begin
			for (int s = 0; s < 4; s++) begin
				for (int i = 0; i < 6; i++) begin
					set_carry(1'(c));
					load_reg(3'd1, $random(seed));
					run_cmd(ops[i], 2'(s), 3'd2, 3'd1, 3'd0, 1'b0, 8'd0);
				end
			end
		end
	endtask

	task automatic test_mul_busy();
		apu_pkg::apu_word_t data;
		logic               err;
		for (int s = 0; s < 4; s++) begin
			load_reg(3'd1, $random(seed));
			load_reg(3'd2, $random(seed));
			run_cmd(apu_pkg::MUL, 2'(s), 3'd3, 3'd1, 3'd2, 1'b0, 8'd0);
		end
		load_reg(3'd1, $random(seed));
		load_reg(3'd2, $random(seed));
		issue_cmd(apu_pkg::ADD, 2'd3, 3'd5, 3'd1, 3'd2, 1'b0, 8'd0);
		apb_read(apu_pkg::APU_ADDR_STATUS, data, err);
		check_busy(1'b1, data[0]);
		read_reg_check(3'd5);
		read_status_check(1'b0);
		issue_cmd(apu_pkg::MUL, 2'd3, 3'd4, 3'd1, 3'd2, 1'b0, 8'd0);
		read_reg_check(3'd4);                              // Access lands in WRITEBACK
		if (last_waits == 0) begin
			$display("%0t: register read during writeback was not held off", $time);
			proto_errs++;
		end
		read_status_check(1'b0);
	endtask

	task automatic test_errors();
		apu_pkg::apu_word_t data;
		logic               err;
		apb_read(8'h08, data, err);
		check_resp("pslverr on read of 0x08", 1'b1, err);
		apb_write(8'h40, $random(seed), err);
		check_resp("pslverr on write to 0x40", 1'b1, err);
		apb_write(8'h21, $random(seed), err);              // Unaligned in register window
		check_resp("pslverr on write to 0x21", 1'b1, err);
		apb_write(apu_pkg::APU_ADDR_STATUS, 32'h0000_000f, err);
		check_resp("pslverr on status write", 1'b1, err);
		for (int i = 0; i < 8; i++) begin
			read_reg_check(3'(i));
		end
		read_status_check(1'b0);
	endtask

	initial begin
		seed       = 48174;
		word_errs  = 0;
		flag_errs  = 0;
		resp_errs  = 0;
		proto_errs = 0;
		clk        = 1'b0;
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		model_flags = '0;
		for (int i = 0; i < apu_pkg::APU_NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;

		test_reg_access();
		test_logic();
		test_arith();
		test_shift();
		test_mul_busy();
		test_errors();

		$display("Errors: word %0d, flags %0d, response %0d, protocol %0d",
			word_errs, flag_errs, resp_errs, proto_errs);
		if (word_errs + flag_errs + resp_errs + proto_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- apu.f
+incdir+sim
source/apu_pkg.sv
source/apu_alu.sv
source/apu_regfile.sv
source/apu_ctrl.sv
source/apu_top.sv
sim/apu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the APU testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --top-module apu_tb -Mdir obj_dir -f apu.f > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vapu_tb > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$sim_log"; then
	exit 1
fi
if ! grep -q "STATUS: PASS" "$sim_log"; then
	echo "No status line found in $sim_log"
	exit 1
fi
exit 0
